// File: design/conv1_params.svh
`ifndef CONV1_PARAMS_SVH
`define CONV1_PARAMS_SVH

// data widths
`define CONV_ACT_W        12
`define CONV_PARAM_W      8
`define CONV_ACC_W        24
`define CONV_WORD_W       192

// layer geometry
`define CONV_CH           4
`define CONV_POS          6
`define CONV_STEPS        16
`define CONV_DRAIN        6

// bank addressing
`define CONV_ADDR_W       6
`define CONV_WADDR_W      10
`define CONV_A_ROW_STRIDE 6
`define CONV_B_ROW_STRIDE 3

// quantization
`define CONV_BIAS_SHIFT   8
`define CONV_Q_SHIFT      7
`define CONV_Q_ROUND      64

`endif

// File: design/conv1_pkg.sv
`default_nettype none
`include "conv1_params.svh"

package conv1_pkg;

  typedef enum logic [1:0]
  {
    IDLE,
    RUN,
    DONE
  } conv_state_e;

  typedef logic signed [`CONV_ACT_W-1:0] act_t;

  // weights and biases share one width
  typedef logic signed [`CONV_PARAM_W-1:0] weight_t;

  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // one input channel's 4x4 patch, row-major
  typedef act_t [0:3][0:3] window_t;

  typedef weight_t [0:2][0:2] kernel_t;

endpackage

`default_nettype wire

// File: design/conv_sched_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

interface conv_sched_if ();

  // one weight step, aligned with the window stage output
  logic                         load;
  logic [$clog2(`CONV_CH)-1:0]  in_ch;
  logic [$clog2(`CONV_CH)-1:0]  out_ch;
  logic [$clog2(`CONV_POS)-1:0] pos_h;
  logic [$clog2(`CONV_POS)-1:0] pos_w;

  modport seq (output load, in_ch, out_ch, pos_h, pos_w);

  modport stage (input load, in_ch, out_ch, pos_h, pos_w);

endinterface

`default_nettype wire

// File: design/conv_result_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

interface conv_result_if import conv1_pkg::*; ();

  logic                         valid;
  logic [$clog2(`CONV_CH)-1:0]  out_ch;
  logic [$clog2(`CONV_POS)-1:0] pos_h;
  logic [$clog2(`CONV_POS)-1:0] pos_w;
  // pixel order (0,0) (0,1) (1,0) (1,1)
  acc_t [0:3]                   sum;
  weight_t                      bias;

  modport mac (output valid, out_ch, pos_h, pos_w, sum, bias);

  modport wb (input valid, out_ch, pos_h, pos_w, sum, bias);

endinterface

`default_nettype wire

// File: design/conv1_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_sequencer import conv1_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable,
  output logic                     valid,
  output logic [`CONV_ADDR_W-1:0]  sram_raddr_a0,
  output logic [`CONV_ADDR_W-1:0]  sram_raddr_a1,
  output logic [`CONV_ADDR_W-1:0]  sram_raddr_a2,
  output logic [`CONV_ADDR_W-1:0]  sram_raddr_a3,
  output logic [`CONV_WADDR_W-1:0] sram_raddr_weight,
  output logic [`CONV_ADDR_W-1:0]  sram_raddr_bias,
  conv_sched_if.seq                sched
);

  localparam int STEP_W = $clog2(`CONV_STEPS);
  localparam int POS_W = $clog2(`CONV_POS);
  localparam int CH_W = $clog2(`CONV_CH);
  localparam int DRAIN_W = $clog2(`CONV_DRAIN);

  conv_state_e state;
  logic [STEP_W-1:0] step;
  logic [POS_W-1:0] pos_h;
  logic [POS_W-1:0] pos_w;
  logic issuing;
  logic last_step;
  logic [DRAIN_W-1:0] drain_cnt;
  logic [POS_W-1:0] row_e;
  logic [POS_W-1:0] row_o;
  logic [POS_W-1:0] col_e;
  logic [POS_W-1:0] col_o;
  logic [1:0] load_d;
  logic [STEP_W+2*POS_W-1:0] tag_d1;
  logic [STEP_W+2*POS_W-1:0] tag_d2;

  function automatic logic [`CONV_ADDR_W-1:0] tile_addr(
    input logic [POS_W-1:0] row,
    input logic [POS_W-1:0] col
  );
    return `CONV_ADDR_W'(row * `CONV_A_ROW_STRIDE + col);
  endfunction

  assign last_step = (step == STEP_W'(`CONV_STEPS - 1)) &&
                     (pos_h == POS_W'(`CONV_POS - 1)) &&
                     (pos_w == POS_W'(`CONV_POS - 1));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      issuing <= 1'b0;
      step <= '0;
      pos_h <= '0;
      pos_w <= '0;
      drain_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (enable)
          begin
            state <= RUN;
            issuing <= 1'b1;
          end
        end
        RUN:
        begin
          if (issuing)
          begin
            step <= step + 1'b1;
            if (step == STEP_W'(`CONV_STEPS - 1))
            begin
              if (pos_w == POS_W'(`CONV_POS - 1))
              begin
                pos_w <= '0;
                pos_h <= last_step ? '0 : pos_h + 1'b1;
              end
              else
              begin
                pos_w <= pos_w + 1'b1;
              end
            end
            if (last_step)
              issuing <= 1'b0;
          end
          else
          begin
            // let the last results drain through the pipeline
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == DRAIN_W'(`CONV_DRAIN - 1))
              state <= DONE;
          end
        end
        default:
        begin
          state <= DONE;
        end
      endcase
    end
  end

  assign valid = (state == DONE);

  // even banks hold the tile at ceil(pos/2), odd banks the one at floor(pos/2)
  assign row_e = (pos_h >> 1) + POS_W'(pos_h[0]);
  assign row_o = pos_h >> 1;
  assign col_e = (pos_w >> 1) + POS_W'(pos_w[0]);
  assign col_o = pos_w >> 1;

  assign sram_raddr_a0 = tile_addr(row_e, col_e);
  assign sram_raddr_a1 = tile_addr(row_e, col_o);
  assign sram_raddr_a2 = tile_addr(row_o, col_e);
  assign sram_raddr_a3 = tile_addr(row_o, col_o);

  // step is {out_ch, in_ch}
  assign sram_raddr_weight = `CONV_WADDR_W'(step);
  assign sram_raddr_bias = `CONV_ADDR_W'(step[CH_W +: CH_W]);

  // SRAM read plus window register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      load_d <= '0;
    else
      load_d <= {load_d[0], issuing};
  end

  always_ff @(posedge clk)
  begin
    tag_d1 <= {step, pos_h, pos_w};
    tag_d2 <= tag_d1;
  end

  assign sched.load = load_d[1];
  assign {sched.out_ch, sched.in_ch, sched.pos_h, sched.pos_w} = tag_d2;

endmodule

`default_nettype wire

// File: design/conv1_window.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_window import conv1_pkg::*; (
  input  logic                       clk,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a0,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a1,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a2,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a3,
  input  logic [9*`CONV_PARAM_W-1:0] sram_rdata_weight,
  input  logic [`CONV_PARAM_W-1:0]   sram_rdata_bias,
  conv_sched_if.stage                sched,
  output window_t                    window,
  output kernel_t                    kernel,
  output weight_t                    bias
);

  logic [`CONV_WORD_W-1:0] tile_q [0:3];
  logic [9*`CONV_PARAM_W-1:0] weight_q;

  always_ff @(posedge clk)
  begin
    tile_q[0] <= sram_rdata_a0;
    tile_q[1] <= sram_rdata_a1;
    tile_q[2] <= sram_rdata_a2;
    tile_q[3] <= sram_rdata_a3;
    weight_q <= sram_rdata_weight;
    bias <= sram_rdata_bias;
  end

  // quadrant (qr, qc) is tile (h+qr, w+qc), so an odd position swaps the banks
  always_comb
  begin
    logic [1:0] bank;
    int word;
    window = '0;
    for (int qr = 0; qr < 2; qr++)
    begin
      for (int qc = 0; qc < 2; qc++)
      begin
        bank = {sched.pos_h[0] ^ qr[0], sched.pos_w[0] ^ qc[0]};
        for (int pr = 0; pr < 2; pr++)
        begin
          for (int pc = 0; pc < 2; pc++)
          begin
            word = sched.in_ch * 4 + pr * 2 + pc;
            window[2*qr+pr][2*qc+pc] =
              tile_q[bank][`CONV_WORD_W-1-word*`CONV_ACT_W -: `CONV_ACT_W];
          end
        end
      end
    end
  end

  // first weight sits in the top byte
  always_comb
  begin
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        kernel[i][j] = weight_q[9*`CONV_PARAM_W-1-(3*i+j)*`CONV_PARAM_W -: `CONV_PARAM_W];
  end

endmodule

`default_nettype wire

// File: design/conv1_mac.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_mac import conv1_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  window_t     window,
  input  kernel_t     kernel,
  input  weight_t     bias,
  conv_sched_if.stage sched,
  conv_result_if.mac  result
);

  acc_t dot [0:3];
  acc_t acc [0:3];
  acc_t total [0:3];
  logic last_in;

  // pixel p of the 2x2 tile starts at window offset (p/2, p%2)
  always_comb
  begin
    for (int p = 0; p < 4; p++)
    begin
      dot[p] = '0;
      for (int i = 0; i < 3; i++)
      begin
        for (int j = 0; j < 3; j++)
        begin
          dot[p] += acc_t'($signed(window[p/2+i][p%2+j])) * acc_t'($signed(kernel[i][j]));
        end
      end
      // channel 0 starts a new sum
      total[p] = (sched.in_ch == '0) ? dot[p] : acc[p] + dot[p];
    end
  end

  assign last_in = sched.load && (sched.in_ch == $bits(sched.in_ch)'(`CONV_CH - 1));

  always_ff @(posedge clk)
  begin
    if (sched.load)
    begin
      for (int p = 0; p < 4; p++)
        acc[p] <= total[p];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      result.valid <= 1'b0;
    else
      result.valid <= last_in;
  end

  always_ff @(posedge clk)
  begin
    if (last_in)
    begin
      for (int p = 0; p < 4; p++)
        result.sum[p] <= total[p];
      result.bias <= bias;
      result.out_ch <= sched.out_ch;
      result.pos_h <= sched.pos_h;
      result.pos_w <= sched.pos_w;
    end
  end

endmodule

`default_nettype wire

// File: design/conv1_writeback.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_writeback import conv1_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  conv_result_if.wb                 result,
  output logic                      sram_wen_b0,
  output logic                      sram_wen_b1,
  output logic                      sram_wen_b2,
  output logic                      sram_wen_b3,
  output logic [`CONV_ADDR_W-1:0]   sram_waddr_b,
  output logic [`CONV_CH*4-1:0]     sram_wordmask_b,
  output logic [`CONV_WORD_W-1:0]   sram_wdata_b
);

  logic signed [`CONV_ACC_W:0] bias_ext;
  logic signed [`CONV_ACC_W:0] biased [0:3];
  logic signed [`CONV_ACC_W:0] rounded [0:3];
  act_t q [0:3];
  logic [1:0] bank;
  logic [`CONV_WORD_W-1:0] wdata_next;
  logic [`CONV_CH*4-1:0] mask_next;

  assign bias_ext = $signed(result.bias) <<< `CONV_BIAS_SHIFT;

  always_comb
  begin
    for (int p = 0; p < 4; p++)
    begin
      biased[p] = $signed(result.sum[p]) + bias_ext;
      rounded[p] = (biased[p] + `CONV_Q_ROUND) >>> `CONV_Q_SHIFT;
      // relu first, so only the upper bound can saturate
      if (biased[p] <= 0)
        q[p] = '0;
      else if (rounded[p] > 2**(`CONV_ACT_W-1) - 1)
        q[p] = act_t'(2**(`CONV_ACT_W-1) - 1);
      else
        q[p] = act_t'(rounded[p]);
    end
  end

  // output channel k takes the same slot as input channel k
  always_comb
  begin
    wdata_next = '0;
    mask_next = '1;
    for (int p = 0; p < 4; p++)
      wdata_next[`CONV_WORD_W-1-(result.out_ch*4+p)*`CONV_ACT_W -: `CONV_ACT_W] = q[p];
    mask_next[`CONV_CH*4-1-result.out_ch*4 -: 4] = '0;
  end

  assign bank = {result.pos_h[0], result.pos_w[0]};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      {sram_wen_b3, sram_wen_b2, sram_wen_b1, sram_wen_b0} <= 4'b1111;
      sram_wordmask_b <= '1;
    end
    else
    begin
      {sram_wen_b3, sram_wen_b2, sram_wen_b1, sram_wen_b0} <= ~(4'(result.valid) << bank);
      sram_wordmask_b <= result.valid ? mask_next : '1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (result.valid)
    begin
      sram_waddr_b <= `CONV_ADDR_W'((result.pos_h >> 1) * `CONV_B_ROW_STRIDE +
                                    (result.pos_w >> 1));
      sram_wdata_b <= wdata_next;
    end
  end

endmodule

`default_nettype wire

// File: design/conv1.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1 import conv1_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable,
  output logic                       valid,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a0,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a1,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a2,
  input  logic [`CONV_WORD_W-1:0]    sram_rdata_a3,
  input  logic [9*`CONV_PARAM_W-1:0] sram_rdata_weight,
  input  logic [`CONV_PARAM_W-1:0]   sram_rdata_bias,
  output logic [`CONV_ADDR_W-1:0]    sram_raddr_a0,
  output logic [`CONV_ADDR_W-1:0]    sram_raddr_a1,
  output logic [`CONV_ADDR_W-1:0]    sram_raddr_a2,
  output logic [`CONV_ADDR_W-1:0]    sram_raddr_a3,
  output logic [`CONV_WADDR_W-1:0]   sram_raddr_weight,
  output logic [`CONV_ADDR_W-1:0]    sram_raddr_bias,
  output logic                       sram_wen_b0,
  output logic                       sram_wen_b1,
  output logic                       sram_wen_b2,
  output logic                       sram_wen_b3,
  output logic [`CONV_CH*4-1:0]      sram_wordmask_b,
  output logic [`CONV_ADDR_W-1:0]    sram_waddr_b,
  output logic [`CONV_WORD_W-1:0]    sram_wdata_b
);

  window_t window;
  kernel_t kernel;
  weight_t bias;

  conv_sched_if sched ();
  conv_result_if result ();

  conv1_sequencer u_sequencer (
    .clk               (clk),
    .rst_n             (rst_n),
    .enable            (enable),
    .valid             (valid),
    .sram_raddr_a0     (sram_raddr_a0),
    .sram_raddr_a1     (sram_raddr_a1),
    .sram_raddr_a2     (sram_raddr_a2),
    .sram_raddr_a3     (sram_raddr_a3),
    .sram_raddr_weight (sram_raddr_weight),
    .sram_raddr_bias   (sram_raddr_bias),
    .sched             (sched.seq)
  );

  conv1_window u_window (
    .clk               (clk),
    .sram_rdata_a0     (sram_rdata_a0),
    .sram_rdata_a1     (sram_rdata_a1),
    .sram_rdata_a2     (sram_rdata_a2),
    .sram_rdata_a3     (sram_rdata_a3),
    .sram_rdata_weight (sram_rdata_weight),
    .sram_rdata_bias   (sram_rdata_bias),
    .sched             (sched.stage),
    .window            (window),
    .kernel            (kernel),
    .bias              (bias)
  );

  conv1_mac u_mac (
    .clk    (clk),
    .rst_n  (rst_n),
    .window (window),
    .kernel (kernel),
    .bias   (bias),
    .sched  (sched.stage),
    .result (result.mac)
  );

  conv1_writeback u_writeback (
    .clk             (clk),
    .rst_n           (rst_n),
    .result          (result.wb),
    .sram_wen_b0     (sram_wen_b0),
    .sram_wen_b1     (sram_wen_b1),
    .sram_wen_b2     (sram_wen_b2),
    .sram_wen_b3     (sram_wen_b3),
    .sram_waddr_b    (sram_waddr_b),
    .sram_wordmask_b (sram_wordmask_b),
    .sram_wdata_b    (sram_wdata_b)
  );

endmodule

`default_nettype wire

// File: testbench/conv1_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   valid,
  input logic                   sram_wen_b0,
  input logic                   sram_wen_b1,
  input logic                   sram_wen_b2,
  input logic                   sram_wen_b3,
  input logic [`CONV_CH*4-1:0]  sram_wordmask_b
);

  logic [3:0] wen;

  assign wen = {sram_wen_b3, sram_wen_b2, sram_wen_b1, sram_wen_b0};

  reset_idle: assert property (@(posedge clk) !rst_n |=> (wen == 4'hf && !valid))
    else $error("outputs not idle after reset");

  // one output bank per write
  one_bank: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~wen))
    else $error("more than one output bank enabled");

  mask_slot: assert property (@(posedge clk) disable iff (!rst_n)
    (wen != 4'hf) |-> ($countones(~sram_wordmask_b) == 4))
    else $error("write mask does not select exactly one channel slot");

  mask_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (wen == 4'hf) |-> (sram_wordmask_b == '1))
    else $error("mask active without a write");

  valid_sticky: assert property (@(posedge clk) disable iff (!rst_n) valid |=> valid)
    else $error("valid dropped before reset");

  done_quiet: assert property (@(posedge clk) disable iff (!rst_n) valid |-> (wen == 4'hf))
    else $error("write while valid is high");

endmodule

bind conv1 conv1_properties u_properties (
  .clk             (clk),
  .rst_n           (rst_n),
  .valid           (valid),
  .sram_wen_b0     (sram_wen_b0),
  .sram_wen_b1     (sram_wen_b1),
  .sram_wen_b2     (sram_wen_b2),
  .sram_wen_b3     (sram_wen_b3),
  .sram_wordmask_b (sram_wordmask_b)
);

`default_nettype wire

// File: testbench/conv1_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable,
  input  logic                       valid,
  input  logic                       sram_wen_b0,
  input  logic                       sram_wen_b1,
  input  logic                       sram_wen_b2,
  input  logic                       sram_wen_b3,
  input  logic [`CONV_CH*4-1:0]      sram_wordmask_b,
  input  logic [`CONV_WORD_W-1:0]    act_mem [0:255],
  input  logic [9*`CONV_PARAM_W-1:0] weight_mem [0:15],
  input  logic [`CONV_PARAM_W-1:0]   bias_mem [0:3],
  input  logic [`CONV_WORD_W-1:0]    out_mem [0:255],
  input  logic [1:0]                 mode,
  input  logic                       check_req,
  output logic                       check_done,
  output int                         err_count
);

  logic [3:0] wen;
  logic started;
  logic valid_seen;
  int write_count;
  int errors = 0;

  assign wen = {sram_wen_b3, sram_wen_b2, sram_wen_b1, sram_wen_b0};
  assign err_count = errors;

  // pixel (y, x) of input channel c looked up through its tile
  function automatic int act_pixel(input int c, input int y, input int x);
    int bank;
    int addr;
    int idx;
    logic signed [`CONV_ACT_W-1:0] v;
    bank = 2 * ((y / 2) % 2) + (x / 2) % 2;
    addr = (y / 4) * `CONV_A_ROW_STRIDE + x / 4;
    idx = c * 4 + (y % 2) * 2 + x % 2;
    v = act_mem[bank * 64 + addr][`CONV_WORD_W-1-idx*`CONV_ACT_W -: `CONV_ACT_W];
    return int'(v);
  endfunction

  function automatic int weight_at(input int k, input int c, input int i, input int j);
    logic signed [`CONV_PARAM_W-1:0] v;
    v = weight_mem[k * 4 + c][9*`CONV_PARAM_W-1-(i*3+j)*`CONV_PARAM_W -: `CONV_PARAM_W];
    return int'(v);
  endfunction

  function automatic int expected_pixel(input int k, input int oy, input int ox);
    int sum;
    logic signed [`CONV_PARAM_W-1:0] b;
    sum = 0;
    b = bias_mem[k];
    for (int c = 0; c < `CONV_CH; c++)
      for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
          sum += act_pixel(c, oy + i, ox + j) * weight_at(k, c, i, j);
    sum += int'(b) * (1 << `CONV_BIAS_SHIFT);
    if (sum <= 0)
      return 0;
    sum = (sum + `CONV_Q_ROUND) / (1 << `CONV_Q_SHIFT);
    return (sum > 2047) ? 2047 : sum;
  endfunction

  task automatic report(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic compare_banks();
    int h;
    int w;
    int k;
    int exp;
    int slot;
    int idx;
    logic signed [`CONV_ACT_W-1:0] got;
    for (int n = 0; n < `CONV_POS * `CONV_POS * `CONV_CH * 4; n++)
    begin
      h = n / 96;
      w = (n / 16) % 6;
      k = (n / 4) % 4;
      slot = k * 4 + n % 4;
      exp = expected_pixel(k, 2 * h + (n % 4) / 2, 2 * w + n % 2);
      idx = (2 * (h % 2) + w % 2) * 64 + (h / 2) * `CONV_B_ROW_STRIDE + w / 2;
      got = out_mem[idx][`CONV_WORD_W-1-slot*`CONV_ACT_W -: `CONV_ACT_W];
      if (int'(got) != exp)
        report($sformatf("position (%0d,%0d) ch %0d pixel %0d: got %0d, expected %0d",
                         h, w, k, n % 4, got, exp));
      if (mode == 2'd1 && int'(got) != 2047)
        report($sformatf("position (%0d,%0d) ch %0d not saturated: %0d", h, w, k, got));
      if (mode == 2'd2 && got != 0)
        report($sformatf("position (%0d,%0d) ch %0d not clamped to zero: %0d", h, w, k, got));
    end
    if (write_count != `CONV_POS * `CONV_POS * `CONV_CH)
      report($sformatf("%0d writes, expected %0d", write_count,
                       `CONV_POS * `CONV_POS * `CONV_CH));
  endtask

  always @(posedge clk)
  begin
    check_done <= 1'b0;
    if (!rst_n)
    begin
      started <= 1'b0;
      valid_seen <= 1'b0;
      write_count <= 0;
    end
    else
    begin
      if (enable)
        started <= 1'b1;
      if (!started && (valid || wen != 4'hf || sram_wordmask_b != '1))
        report("outputs not idle before enable");
      if (wen != 4'hf)
      begin
        write_count <= write_count + 1;
        if (valid)
          report("write after valid went high");
      end
      if (valid)
        valid_seen <= 1'b1;
      else if (valid_seen)
        report("valid dropped before reset");
    end
    if (check_req)
    begin
      compare_banks();
      check_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: testbench/conv1_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv1_params.svh"

module conv1_tb;

  localparam int VALID_LIMIT = 2000;
  localparam int CHECK_LIMIT = 10;

  logic clk;
  logic rst_n = 1'b0;
  logic enable = 1'b0;
  logic valid;
  logic [`CONV_WORD_W-1:0] sram_rdata_a0 = '0;
  logic [`CONV_WORD_W-1:0] sram_rdata_a1 = '0;
  logic [`CONV_WORD_W-1:0] sram_rdata_a2 = '0;
  logic [`CONV_WORD_W-1:0] sram_rdata_a3 = '0;
  logic [9*`CONV_PARAM_W-1:0] sram_rdata_weight = '0;
  logic [`CONV_PARAM_W-1:0] sram_rdata_bias = '0;
  logic [`CONV_ADDR_W-1:0] sram_raddr_a0;
  logic [`CONV_ADDR_W-1:0] sram_raddr_a1;
  logic [`CONV_ADDR_W-1:0] sram_raddr_a2;
  logic [`CONV_ADDR_W-1:0] sram_raddr_a3;
  logic [`CONV_WADDR_W-1:0] sram_raddr_weight;
  logic [`CONV_ADDR_W-1:0] sram_raddr_bias;
  logic sram_wen_b0;
  logic sram_wen_b1;
  logic sram_wen_b2;
  logic sram_wen_b3;
  logic [`CONV_CH*4-1:0] sram_wordmask_b;
  logic [`CONV_ADDR_W-1:0] sram_waddr_b;
  logic [`CONV_WORD_W-1:0] sram_wdata_b;

  // index is bank * 64 + address
  logic [`CONV_WORD_W-1:0] act_mem [0:255];
  logic [`CONV_WORD_W-1:0] out_mem [0:255];
  logic [9*`CONV_PARAM_W-1:0] weight_mem [0:15];
  logic [`CONV_PARAM_W-1:0] bias_mem [0:3];

  logic [1:0] mode = '0;
  logic check_req = 1'b0;
  logic check_done;
  int err_count;
  logic [31:0] lcg_state = 32'd30;
  logic timed_out = 1'b0;
  int tests_run = 0;

  conv1 UUT (.*);

  conv1_checker u_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[31:16]);
  endfunction

  // mode 0 random, 1 large positive, 2 small values under a strongly negative bias
  task automatic fill_memories(input logic [1:0] m);
    logic [`CONV_WORD_W-1:0] word;
    logic [9*`CONV_PARAM_W-1:0] wword;
    int r;
    for (int a = 0; a < 256; a++)
    begin
      for (int i = 0; i < 16; i++)
      begin
        r = next_rand();
        word[`CONV_WORD_W-1-i*`CONV_ACT_W -: `CONV_ACT_W] =
          (m == 2'd1) ? 12'(1024 + r % 1024) : (m == 2'd2) ? 12'(r % 64) : 12'(r);
      end
      act_mem[a] = word;
    end
    for (int a = 0; a < 16; a++)
    begin
      for (int i = 0; i < 9; i++)
      begin
        r = next_rand();
        wword[9*`CONV_PARAM_W-1-i*`CONV_PARAM_W -: `CONV_PARAM_W] =
          (m == 2'd1) ? 8'(64 + r % 64) : (m == 2'd2) ? 8'(r % 16 - 8) : 8'(r);
      end
      weight_mem[a] = wword;
    end
    for (int a = 0; a < 4; a++)
      bias_mem[a] = (m == 2'd2) ? 8'h80 : 8'(next_rand());
  endtask

  // SRAM models with one cycle read latency and masked writes
  always @(posedge clk)
  begin
    logic [3:0] wen;
    logic [`CONV_WORD_W-1:0] word;
    int idx;
    wen = {sram_wen_b3, sram_wen_b2, sram_wen_b1, sram_wen_b0};
    sram_rdata_a0 <= act_mem[{2'd0, sram_raddr_a0}];
    sram_rdata_a1 <= act_mem[{2'd1, sram_raddr_a1}];
    sram_rdata_a2 <= act_mem[{2'd2, sram_raddr_a2}];
    sram_rdata_a3 <= act_mem[{2'd3, sram_raddr_a3}];
    sram_rdata_weight <= weight_mem[sram_raddr_weight[3:0]];
    sram_rdata_bias <= bias_mem[sram_raddr_bias[1:0]];
    if (!rst_n)
    begin
      for (int a = 0; a < 256; a++)
        out_mem[a] <= ~{24{8'(a)}};
    end
    else
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (!wen[b])
        begin
          idx = b * 64 + int'(sram_waddr_b);
          word = out_mem[idx];
          for (int i = 0; i < 16; i++)
            if (!sram_wordmask_b[15-i])
              word[`CONV_WORD_W-1-i*`CONV_ACT_W -: `CONV_ACT_W] =
                sram_wdata_b[`CONV_WORD_W-1-i*`CONV_ACT_W -: `CONV_ACT_W];
          out_mem[idx] <= word;
        end
      end
    end
  end

  task automatic run_test(input logic [1:0] m, input string name);
    int cycles;
    int errs_before;
    errs_before = err_count;
    @(posedge clk);
    rst_n <= 1'b0;
    enable <= 1'b0;
    mode <= m;
    fill_memories(m);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // idle stretch before the start strobe
    repeat (5) @(posedge clk);
    enable <= 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    cycles = 0;
    while (!valid && cycles < VALID_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!valid)
    begin
      $display("timeout: valid never went high in the %s run", name);
      timed_out = 1'b1;
    end
    else
    begin
      repeat (50) @(posedge clk);
      check_req <= 1'b1;
      @(posedge clk);
      check_req <= 1'b0;
      cycles = 0;
      while (!check_done && cycles < CHECK_LIMIT)
      begin
        @(posedge clk);
        cycles++;
      end
      if (!check_done)
      begin
        $display("timeout: the checker never finished the %s run", name);
        timed_out = 1'b1;
      end
      else
        $display("[%0t] %s run finished with %0d errors", $time, name, err_count - errs_before);
    end
    tests_run++;
  endtask

  initial
  begin
    run_test(2'd0, "random");
    if (!timed_out)
      run_test(2'd1, "saturation");
    if (!timed_out)
      run_test(2'd2, "relu");
    $display("%0d runs, %0d errors, timeout %0d", tests_run, err_count, timed_out);
    if (err_count == 0 && !timed_out)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: conv1.f
+incdir+design
design/conv1_pkg.sv
design/conv_sched_if.sv
design/conv_result_if.sv
design/conv1_sequencer.sv
design/conv1_window.sv
design/conv1_mac.sv
design/conv1_writeback.sv
design/conv1.sv
testbench/conv1_properties.sv
testbench/conv1_checker.sv
testbench/conv1_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = conv1_tb
FILELIST  = conv1.f
LOG       = sim.log
FAIL_MSG  = test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
